// File: rtl/dp_consts.svh
// Shared constants for the DisplayPort control plane
// DP_LOCK_CNT_W is shortened for simulation, use 16 on hardware
// Wishbone addresses are word addresses on an 8-bit data bus
`ifndef DP_CONSTS_SVH
`define DP_CONSTS_SVH

// Lock qualification counter, release after 2**(W-1) locked cycles
`define DP_LOCK_CNT_W 8

// Video path widths
`define DP_PIX_W 24
`define DP_LINE_CNT_W 12

// Reconfiguration register map
`define DP_WB_ADR_W 2
`define DP_ADDR_PORT 2'd0
`define DP_ADDR_RATE 2'd1
`define DP_ADDR_START 2'd2
`define DP_ADDR_STATUS 2'd3

// Busy period of the transceiver model after a start write
`define DP_RECONF_CYCLES 20

`endif

// File: rtl/dp_pkg.sv
// Types shared by the RTL and the testbench
// Link rate code 3 is reserved; the type does not name it
`default_nettype none

package dp_pkg;

	// ****************************************
	// Link rates
	// ****************************************

	// DisplayPort main link rates as coded on the rate request ports
	// RBR  1.62 Gbps per lane
	// HBR  2.70 Gbps per lane
	// HBR2 5.40 Gbps per lane
	typedef enum logic [1:0]
	{
		RBR  = 2'd0,
		HBR  = 2'd1,
		HBR2 = 2'd2
	} link_rate_t;

	// ****************************************
	// Port selection
	// ****************************************

	// Which side of the link a reconfiguration targets
	// Also the value written to the port register
	typedef enum logic
	{
		RX = 1'b0,
		TX = 1'b1
	} port_id_t;

endpackage

`default_nettype wire

// File: rtl/wb_if.sv
// Wishbone classic bus, single master and single slave
// No wait states beyond the slave's registered ack, no bursts
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

interface wb_if;

	// Cycle framing
	logic cyc;
	logic stb;
	logic we;

	// Address and data
	logic [`DP_WB_ADR_W-1:0] adr;
	logic [7:0] dat_w;
	logic [7:0] dat_r;

	// Transfer done, one cycle per access
	logic ack;

	// Reconfiguration manager side
	modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);

	// Register block side
	modport slave (input cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface

`default_nettype wire

// File: rtl/lock_reset_seq.sv
// Releases the system reset once both PLLs have held lock long enough
// Lock inputs are assumed synchronous to clk
// pll_unstable is cleared only by the top-level reset
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module lock_reset_seq (
	input  wire  clk,
	input  wire  reset,
	input  wire  video_pll_locked,
	input  wire  xcvr_pll_locked,
	output logic sys_ready,
	output logic pll_unstable
);

	// Consecutive cycles with both PLLs locked
	logic [`DP_LOCK_CNT_W-1:0] lock_cnt;
	logic both_locked;

	assign both_locked = video_pll_locked & xcvr_pll_locked;

	// ****************************************
	// Lock qualification counter
	// ****************************************

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			lock_cnt <= '0;
		// Any unlocked sample restarts qualification
		else if (!both_locked)
			lock_cnt <= '0;
		// Stop counting once the top bit is set
		else if (!lock_cnt[`DP_LOCK_CNT_W-1])
			lock_cnt <= lock_cnt + 1'b1;
	end

	// Top bit doubles as the release flag
	assign sys_ready = lock_cnt[`DP_LOCK_CNT_W-1];

	// Sticky lock loss, only counted after release
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			pll_unstable <= 1'b0;
		else if (sys_ready && !both_locked)
			pll_unstable <= 1'b1;
	end

	// Release is only withdrawn after a lost lock
	assert property (@(posedge clk) disable iff (reset)
		$fell(sys_ready) |-> !$past(both_locked))
		else $error("sys_ready fell with both PLLs locked");

endmodule

`default_nettype wire

// File: rtl/reconfig_mgr.sv
// Turns rx and tx link rate requests into Wishbone register sequences
// Receive wins when both ports request in the same cycle
// Reserved rate code 3 is acked without any bus traffic
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module reconfig_mgr (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 rx_req,
	input  wire dp_pkg::link_rate_t rx_rate,
	output logic                rx_ack,
	output logic                rx_busy,
	input  wire                 tx_req,
	input  wire dp_pkg::link_rate_t tx_rate,
	output logic                tx_ack,
	output logic                tx_busy,
	wb_if.master                wb
);

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_SKIP,
		ST_WR_PORT,
		ST_WR_RATE,
		ST_WR_START,
		ST_POLL
	} state_t;

	state_t state;

	// Request being served
	dp_pkg::port_id_t   sel_port;
	dp_pkg::link_rate_t sel_rate;

	function automatic logic rate_valid(input dp_pkg::link_rate_t rate);
		rate_valid = (rate != dp_pkg::link_rate_t'(2'b11));
	endfunction

	// ****************************************
	// Bus address and data per state
	// ****************************************

	// Held stable by the state while stb waits for ack
	always_comb
	begin
		wb.we    = 1'b1;
		wb.adr   = `DP_ADDR_STATUS;
		wb.dat_w = 8'h00;
		case (state)
			ST_WR_PORT:
			begin
				wb.adr   = `DP_ADDR_PORT;
				wb.dat_w = {7'b0, sel_port};
			end
			ST_WR_RATE:
			begin
				wb.adr   = `DP_ADDR_RATE;
				wb.dat_w = {6'b0, sel_rate};
			end
			ST_WR_START:
			begin
				wb.adr   = `DP_ADDR_START;
				wb.dat_w = 8'h01;
			end
			default:
				wb.we = 1'b0;
		endcase
	end

	// Latch the winner, receive first
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE)
		begin
			if (rx_req)
			begin
				sel_port <= dp_pkg::RX;
				sel_rate <= rx_rate;
			end
			else
			begin
				sel_port <= dp_pkg::TX;
				sel_rate <= tx_rate;
			end
		end
	end

	// ****************************************
	// Sequencer
	// ****************************************

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= ST_IDLE;
			wb.cyc  <= 1'b0;
			wb.stb  <= 1'b0;
			rx_ack  <= 1'b0;
			rx_busy <= 1'b0;
			tx_ack  <= 1'b0;
			tx_busy <= 1'b0;
		end
		else
		begin
			// Acks are single-cycle pulses
			rx_ack <= 1'b0;
			tx_ack <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (rx_req)
					begin
						rx_ack  <= 1'b1;
						rx_busy <= 1'b1;
						state   <= rate_valid(rx_rate) ? ST_WR_PORT : ST_SKIP;
					end
					else if (tx_req)
					begin
						tx_ack  <= 1'b1;
						tx_busy <= 1'b1;
						state   <= rate_valid(tx_rate) ? ST_WR_PORT : ST_SKIP;
					end
				end
				// Reserved rate, end right after the ack cycle
				ST_SKIP:
				begin
					rx_busy <= 1'b0;
					tx_busy <= 1'b0;
					state   <= ST_IDLE;
				end
				default:
				begin
					// Start an access, one idle cycle follows every ack
					if (!wb.stb)
					begin
						wb.cyc <= 1'b1;
						wb.stb <= 1'b1;
					end
					else if (wb.ack)
					begin
						wb.cyc <= 1'b0;
						wb.stb <= 1'b0;
						case (state)
							ST_WR_PORT:  state <= ST_WR_RATE;
							ST_WR_RATE:  state <= ST_WR_START;
							ST_WR_START: state <= ST_POLL;
							default:
							begin
								// Keep polling until the busy bit clears
								if (!wb.dat_r[0])
								begin
									rx_busy <= 1'b0;
									tx_busy <= 1'b0;
									state   <= ST_IDLE;
								end
							end
						endcase
					end
				end
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) rx_ack |=> !rx_ack)
		else $error("rx_ack longer than one cycle");
	assert property (@(posedge clk) disable iff (reset) tx_ack |=> !tx_ack)
		else $error("tx_ack longer than one cycle");
	assert property (@(posedge clk) disable iff (reset) wb.stb |-> wb.cyc)
		else $error("stb without cyc");

endmodule

`default_nettype wire

// File: rtl/xcvr_reconfig_regs.sv
// Register model of the transceiver reconfiguration block
// Status bit 0 stays set for DP_RECONF_CYCLES cycles after a start write
// Rate validity is not checked here
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module xcvr_reconfig_regs (
	input  wire                clk,
	input  wire                reset,
	wb_if.slave                wb,
	output dp_pkg::link_rate_t rx_rate_active,
	output dp_pkg::link_rate_t tx_rate_active
);

	localparam int CNT_W = $clog2(`DP_RECONF_CYCLES + 1);

	// Programmed target and rate
	dp_pkg::port_id_t   port_sel;
	dp_pkg::link_rate_t rate_sel;

	// Remaining busy cycles
	logic [CNT_W-1:0] busy_cnt;
	logic busy;

	// New access, blocked during ack so one strobe gives one ack
	logic access;
	logic wr;

	assign access = wb.cyc & wb.stb & ~wb.ack;
	assign wr     = access & wb.we;
	assign busy   = (busy_cnt != '0);

	// ****************************************
	// Register writes and busy timer
	// ****************************************

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wb.ack         <= 1'b0;
			port_sel       <= dp_pkg::RX;
			rate_sel       <= dp_pkg::RBR;
			rx_rate_active <= dp_pkg::RBR;
			tx_rate_active <= dp_pkg::RBR;
			busy_cnt       <= '0;
		end
		else
		begin
			wb.ack <= access;
			if (wr && wb.adr == `DP_ADDR_PORT)
				port_sel <= dp_pkg::port_id_t'(wb.dat_w[0]);
			if (wr && wb.adr == `DP_ADDR_RATE)
				rate_sel <= dp_pkg::link_rate_t'(wb.dat_w[1:0]);
			// Start commits the stored rate to the chosen port
			if (wr && wb.adr == `DP_ADDR_START && wb.dat_w[0])
			begin
				busy_cnt <= CNT_W'(`DP_RECONF_CYCLES);
				if (port_sel == dp_pkg::RX)
					rx_rate_active <= rate_sel;
				else
					tx_rate_active <= rate_sel;
			end
			else if (busy)
				busy_cnt <= busy_cnt - 1'b1;
		end
	end

	// Read data, valid with ack
	always_ff @(posedge clk)
	begin
		if (access)
		begin
			case (wb.adr)
				`DP_ADDR_PORT:   wb.dat_r <= {7'b0, port_sel};
				`DP_ADDR_RATE:   wb.dat_r <= {6'b0, rate_sel};
				`DP_ADDR_STATUS: wb.dat_r <= {7'b0, busy};
				default:         wb.dat_r <= 8'h00;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) wb.ack |=> !wb.ack)
		else $error("ack high two cycles in a row");

endmodule

`default_nettype wire

// File: rtl/video_sync_gen.sv
// Sync generation from the sink's end-of-line and end-of-frame markers
// Markers are single-cycle pulses; eof comes with the last line's eol
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module video_sync_gen (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          vid_valid,
	input  wire                          vid_eol,
	input  wire                          vid_eof,
	input  wire                          vid_locked,
	input  wire  [`DP_PIX_W-1:0]         vid_data,
	output logic                         out_de,
	output logic                         out_hsync,
	output logic                         out_vsync,
	output logic                         out_locked,
	output logic [`DP_PIX_W-1:0]         out_data,
	output logic [`DP_LINE_CNT_W-1:0]    frame_lines
);

	// Lines seen so far in the current frame
	logic [`DP_LINE_CNT_W-1:0] line_cnt;
	logic [`DP_LINE_CNT_W-1:0] line_cnt_nxt;

	// Count includes an eol arriving with eof
	assign line_cnt_nxt = line_cnt + {{(`DP_LINE_CNT_W-1){1'b0}}, vid_eol};

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			out_de      <= 1'b0;
			out_hsync   <= 1'b0;
			out_vsync   <= 1'b0;
			out_locked  <= 1'b0;
			line_cnt    <= '0;
			frame_lines <= '0;
		end
		else
		begin
			// eol drives h sync, eof drives v sync
			out_de     <= vid_valid;
			out_hsync  <= vid_eol;
			out_vsync  <= vid_eof;
			out_locked <= vid_locked;
			if (vid_eof)
			begin
				frame_lines <= line_cnt_nxt;
				line_cnt    <= '0;
			end
			else
				line_cnt <= line_cnt_nxt;
		end
	end

	// Pixel data, same latency as the syncs
	always_ff @(posedge clk)
		out_data <= vid_data;

endmodule

`default_nettype wire

// File: rtl/dp_link_ctrl.sv
// Control plane top level for the DisplayPort demo
// Everything runs on clk, including the video path
// Reconfiguration logic stays in reset until both PLLs are qualified
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module dp_link_ctrl (
	input  wire                          clk,
	input  wire                          reset,
	// PLL status
	input  wire                          video_pll_locked,
	input  wire                          xcvr_pll_locked,
	output logic                         sys_ready,
	output logic                         pll_unstable,
	// Receive rate request
	input  wire                          rx_reconfig_req,
	input  wire dp_pkg::link_rate_t      rx_link_rate,
	output logic                         rx_reconfig_ack,
	output logic                         rx_reconfig_busy,
	// Transmit rate request
	input  wire                          tx_reconfig_req,
	input  wire dp_pkg::link_rate_t      tx_link_rate,
	output logic                         tx_reconfig_ack,
	output logic                         tx_reconfig_busy,
	// Rates currently applied
	output dp_pkg::link_rate_t           rx_rate_active,
	output dp_pkg::link_rate_t           tx_rate_active,
	// Video from the sink
	input  wire                          vid_valid,
	input  wire                          vid_eol,
	input  wire                          vid_eof,
	input  wire                          vid_locked,
	input  wire  [`DP_PIX_W-1:0]         vid_data,
	// Video with syncs
	output logic                         out_de,
	output logic                         out_hsync,
	output logic                         out_vsync,
	output logic                         out_locked,
	output logic [`DP_PIX_W-1:0]         out_data,
	output logic [`DP_LINE_CNT_W-1:0]    frame_lines
);

	// Held in reset until the PLLs are qualified
	logic ctrl_reset;

	wb_if wb_bus ();

	assign ctrl_reset = reset | ~sys_ready;

	// ****************************************
	// Block instances
	// ****************************************

	lock_reset_seq u_lock_seq (
		.clk              (clk),
		.reset            (reset),
		.video_pll_locked (video_pll_locked),
		.xcvr_pll_locked  (xcvr_pll_locked),
		.sys_ready        (sys_ready),
		.pll_unstable     (pll_unstable)
	);

	reconfig_mgr u_mgr (
		.clk     (clk),
		.reset   (ctrl_reset),
		.rx_req  (rx_reconfig_req),
		.rx_rate (rx_link_rate),
		.rx_ack  (rx_reconfig_ack),
		.rx_busy (rx_reconfig_busy),
		.tx_req  (tx_reconfig_req),
		.tx_rate (tx_link_rate),
		.tx_ack  (tx_reconfig_ack),
		.tx_busy (tx_reconfig_busy),
		.wb      (wb_bus.master)
	);

	xcvr_reconfig_regs u_regs (
		.clk            (clk),
		.reset          (ctrl_reset),
		.wb             (wb_bus.slave),
		.rx_rate_active (rx_rate_active),
		.tx_rate_active (tx_rate_active)
	);

	video_sync_gen u_sync (
		.clk         (clk),
		.reset       (reset),
		.vid_valid   (vid_valid),
		.vid_eol     (vid_eol),
		.vid_eof     (vid_eof),
		.vid_locked  (vid_locked),
		.vid_data    (vid_data),
		.out_de      (out_de),
		.out_hsync   (out_hsync),
		.out_vsync   (out_vsync),
		.out_locked  (out_locked),
		.out_data    (out_data),
		.frame_lines (frame_lines)
	);

endmodule

`default_nettype wire

// File: tb/tb_dp_link_ctrl.sv
// Self-checking testbench for the DisplayPort control plane
// Steps come from tb/dp_link_ctrl_golden.txt, run from the project root
// At most 64 golden steps, inputs change on the rising edge, checks on the falling edge
`timescale 1ns/10ps
`default_nettype none
`include "dp_consts.svh"

module tb_dp_link_ctrl;

	localparam int MAX_STEPS   = 64;
	// Per-port completion budget for one reconfiguration
	localparam int RECONF_WAIT = 60;

	logic clk;
	logic reset;
	logic video_pll_locked;
	logic xcvr_pll_locked;
	logic sys_ready;
	logic pll_unstable;
	logic rx_reconfig_req;
	dp_pkg::link_rate_t rx_link_rate;
	logic rx_reconfig_ack;
	logic rx_reconfig_busy;
	logic tx_reconfig_req;
	dp_pkg::link_rate_t tx_link_rate;
	logic tx_reconfig_ack;
	logic tx_reconfig_busy;
	dp_pkg::link_rate_t rx_rate_active;
	dp_pkg::link_rate_t tx_rate_active;
	logic vid_valid;
	logic vid_eol;
	logic vid_eof;
	logic vid_locked;
	logic [`DP_PIX_W-1:0] vid_data;
	logic out_de;
	logic out_hsync;
	logic out_vsync;
	logic out_locked;
	logic [`DP_PIX_W-1:0] out_data;
	logic [`DP_LINE_CNT_W-1:0] frame_lines;

	// Golden steps, kind plus four integer columns
	logic [63:0] step_kind [0:MAX_STEPS-1];
	int step_arg [0:MAX_STEPS-1][0:3];
	int step_count;
	bit load_failed;

	// Bookkeeping
	int step_errs;
	int pass_count;
	int fail_count;
	int cycle_count = 0;
	int cycle_limit = 0;
	int seed_val;

	// Video inputs of the previous cycle, what the outputs must show now
	logic exp_de;
	logic exp_hsync;
	logic exp_vsync;
	logic exp_locked;
	logic [`DP_PIX_W-1:0] exp_data;

	dp_link_ctrl DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Run limit, set once the golden file is loaded
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ****************************************
	// Reporting
	// ****************************************

	task automatic report_mismatch(input string test, input string what,
		input int exp, input int act);
		$display("Fail %s %s: expected %0d, actual %0d", test, what, exp, act);
		step_errs++;
	endtask

	task automatic report_problem(input string test, input string msg);
		$display("Error in %s: %s", test, msg);
		step_errs++;
	endtask

	function automatic string kind_label(input logic [63:0] kind);
		case (kind)
			"lock":  kind_label = "lock";
			"loss":  kind_label = "loss";
			"rx":    kind_label = "rx";
			"tx":    kind_label = "tx";
			"both":  kind_label = "both";
			"frame": kind_label = "frame";
			default: kind_label = "unknown";
		endcase
	endfunction

	// ****************************************
	// Golden file
	// ****************************************

	// Lines starting with # are skipped, others hold kind and four numbers
	task automatic load_golden();
		int fd;
		int code;
		int total;
		bit done;
		logic [63:0] tok;
		logic [8*128-1:0] rest;
		int a, b, c, d;
		step_count = 0;
		total = 0;
		done = 1'b0;
		fd = $fopen("tb/dp_link_ctrl_golden.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open golden file tb/dp_link_ctrl_golden.txt");
			load_failed = 1'b1;
		end
		else
		begin
			while (!done)
			begin
				code = $fscanf(fd, "%s", tok);
				if (code != 1)
					done = 1'b1;
				else if (tok == "#")
					code = $fgets(rest, fd);
				else
				begin
					code = $fscanf(fd, "%d %d %d %d", a, b, c, d);
					if (code != 4 || step_count >= MAX_STEPS)
					begin
						$display("Golden file line after step %0d is malformed", step_count);
						load_failed = 1'b1;
						done = 1'b1;
					end
					else
					begin
						step_kind[step_count] = tok;
						step_arg[step_count][0] = a;
						step_arg[step_count][1] = b;
						step_arg[step_count][2] = c;
						step_arg[step_count][3] = d;
						step_count++;
						// Cycle budget of this step
						case (tok)
							"lock":  total += b;
							"loss":  total += a;
							"both":  total += 2 * RECONF_WAIT + 8;
							"frame": total += a * (b + 1) + 4;
							default: total += RECONF_WAIT + 8;
						endcase
					end
				end
			end
			$fclose(fd);
		end
		// Double the budget plus reset and slack
		cycle_limit = 2 * total + 200;
	endtask

	// ****************************************
	// PLL lock steps
	// ****************************************

	task automatic run_lock(input string name, input int low_at, input int high_by);
		int n;
		@(negedge clk);
		// Reset state of the outputs
		if (sys_ready !== 1'b0)
			report_mismatch(name, "sys_ready after reset", 0, sys_ready);
		if (pll_unstable !== 1'b0)
			report_mismatch(name, "pll_unstable after reset", 0, pll_unstable);
		if ({rx_reconfig_ack, rx_reconfig_busy, tx_reconfig_ack, tx_reconfig_busy} !== 4'b0)
			report_problem(name, "handshake outputs not low after reset");
		if ({out_de, out_hsync, out_vsync} !== 3'b0)
			report_problem(name, "video outputs not low after reset");
		@(posedge clk);
		video_pll_locked <= 1'b1;
		xcvr_pll_locked  <= 1'b1;
		repeat (low_at) @(posedge clk);
		@(negedge clk);
		if (sys_ready !== 1'b0)
			report_mismatch(name, "sys_ready early", 0, sys_ready);
		n = low_at;
		while (sys_ready !== 1'b1 && n < high_by)
		begin
			@(posedge clk);
			@(negedge clk);
			n++;
		end
		if (sys_ready !== 1'b1)
			report_problem(name, "sys_ready not released in time");
	endtask

	// One-cycle drop of the transceiver PLL lock
	task automatic run_loss(input string name, input int recover_by);
		int n;
		@(posedge clk);
		xcvr_pll_locked <= 1'b0;
		@(posedge clk);
		xcvr_pll_locked <= 1'b1;
		@(negedge clk);
		if (sys_ready !== 1'b0)
			report_mismatch(name, "sys_ready after loss", 0, sys_ready);
		if (pll_unstable !== 1'b1)
			report_mismatch(name, "pll_unstable after loss", 1, pll_unstable);
		n = 0;
		while (sys_ready !== 1'b1 && n < recover_by)
		begin
			@(posedge clk);
			@(negedge clk);
			n++;
		end
		if (sys_ready !== 1'b1)
			report_problem(name, "sys_ready did not recover after lock loss");
		// Sticky until the top-level reset
		if (pll_unstable !== 1'b1)
			report_mismatch(name, "pll_unstable after recovery", 1, pll_unstable);
	endtask

	// ****************************************
	// Rate requests
	// ****************************************

	task automatic run_reconfig(input string name, input bit use_rx, input bit use_tx,
		input logic [1:0] rx_code, input logic [1:0] tx_code,
		input logic [1:0] exp_rx, input logic [1:0] exp_tx);
		int n;
		int limit;
		int rx_acks;
		int tx_acks;
		int rx_fall;
		int tx_fall;
		bit rx_done;
		bit tx_done;
		// Random idle gap before the request
		repeat ($urandom_range(1, 8)) @(posedge clk);
		limit   = RECONF_WAIT * (int'(use_rx) + int'(use_tx));
		rx_acks = 0;
		tx_acks = 0;
		rx_fall = 0;
		tx_fall = 0;
		rx_done = !use_rx;
		tx_done = !use_tx;
		@(posedge clk);
		if (use_rx)
		begin
			rx_reconfig_req <= 1'b1;
			rx_link_rate    <= dp_pkg::link_rate_t'(rx_code);
		end
		if (use_tx)
		begin
			tx_reconfig_req <= 1'b1;
			tx_link_rate    <= dp_pkg::link_rate_t'(tx_code);
		end
		n = 0;
		while (!(rx_done && tx_done) && n < limit)
		begin
			@(negedge clk);
			n++;
			if (rx_reconfig_ack === 1'b1)
			begin
				rx_acks++;
				if (rx_reconfig_busy !== 1'b1)
					report_problem(name, "rx busy not raised with its ack");
			end
			if (tx_reconfig_ack === 1'b1)
			begin
				tx_acks++;
				if (tx_reconfig_busy !== 1'b1)
					report_problem(name, "tx busy not raised with its ack");
			end
			// Busy falling after the ack marks the end of a sequence
			if (rx_acks > 0 && !rx_done && rx_reconfig_busy === 1'b0)
			begin
				rx_done = 1'b1;
				rx_fall = n;
			end
			if (tx_acks > 0 && !tx_done && tx_reconfig_busy === 1'b0)
			begin
				tx_done = 1'b1;
				tx_fall = n;
			end
			@(posedge clk);
			if (rx_acks > 0)
				rx_reconfig_req <= 1'b0;
			if (tx_acks > 0)
				tx_reconfig_req <= 1'b0;
		end
		if (!rx_done)
			report_problem(name, "rx request did not complete in time");
		if (!tx_done)
			report_problem(name, "tx request did not complete in time");
		if (rx_acks != int'(use_rx))
			report_mismatch(name, "rx ack pulses", use_rx, rx_acks);
		if (tx_acks != int'(use_tx))
			report_mismatch(name, "tx ack pulses", use_tx, tx_acks);
		// Receive has priority
		if (use_rx && use_tx && rx_done && tx_done && rx_fall >= tx_fall)
			report_problem(name, "tx busy fell before rx busy");
		@(negedge clk);
		if (rx_rate_active !== exp_rx)
			report_mismatch(name, "rx_rate_active", exp_rx, rx_rate_active);
		if (tx_rate_active !== exp_tx)
			report_mismatch(name, "tx_rate_active", exp_tx, tx_rate_active);
	endtask

	// ****************************************
	// Video frames
	// ****************************************

	// Pixel pattern depends on line and pixel index
	function automatic logic [`DP_PIX_W-1:0] pixel_value(input int line, input int pix);
		pixel_value = {line[7:0], pix[15:0]} ^ 24'ha5c35a;
	endfunction

	task automatic capture_video();
		exp_de     = vid_valid;
		exp_hsync  = vid_eol;
		exp_vsync  = vid_eof;
		exp_locked = vid_locked;
		exp_data   = vid_data;
	endtask

	// Drive one cycle, then compare outputs with last cycle's inputs
	task automatic video_cycle(input string name, input logic valid, input logic eol,
		input logic eof, input logic [`DP_PIX_W-1:0] data);
		@(posedge clk);
		vid_valid  <= valid;
		vid_eol    <= eol;
		vid_eof    <= eof;
		vid_locked <= 1'b1;
		vid_data   <= data;
		@(negedge clk);
		if (out_de !== exp_de)
			report_mismatch(name, "out_de", exp_de, out_de);
		if (out_hsync !== exp_hsync)
			report_mismatch(name, "out_hsync", exp_hsync, out_hsync);
		if (out_vsync !== exp_vsync)
			report_mismatch(name, "out_vsync", exp_vsync, out_vsync);
		if (out_locked !== exp_locked)
			report_mismatch(name, "out_locked", exp_locked, out_locked);
		if (out_data !== exp_data)
			report_mismatch(name, "out_data", exp_data, out_data);
		capture_video();
	endtask

	task automatic run_frame(input string name, input int lines, input int pixels,
		input int exp_lines);
		int l;
		int p;
		logic last;
		@(negedge clk);
		capture_video();
		for (l = 0; l < lines; l++)
		begin
			for (p = 0; p < pixels; p++)
			begin
				last = (p == pixels - 1);
				video_cycle(name, 1'b1, last, last && (l == lines - 1), pixel_value(l, p));
			end
			// Blanking cycle between lines
			video_cycle(name, 1'b0, 1'b0, 1'b0, '0);
		end
		video_cycle(name, 1'b0, 1'b0, 1'b0, '0);
		if (frame_lines !== exp_lines)
			report_mismatch(name, "frame_lines", exp_lines, frame_lines);
	endtask

	// ****************************************
	// Main sequence
	// ****************************************

	initial
	begin
		int i;
		string name;
		seed_val = $urandom(32'hb7de2b46);
		reset            = 1'b1;
		video_pll_locked = 1'b0;
		xcvr_pll_locked  = 1'b0;
		rx_reconfig_req  = 1'b0;
		rx_link_rate     = dp_pkg::RBR;
		tx_reconfig_req  = 1'b0;
		tx_link_rate     = dp_pkg::RBR;
		vid_valid        = 1'b0;
		vid_eol          = 1'b0;
		vid_eof          = 1'b0;
		vid_locked       = 1'b0;
		vid_data         = '0;
		pass_count       = 0;
		fail_count       = 0;
		load_failed      = 1'b0;
		capture_video();
		load_golden();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		for (i = 0; i < step_count; i++)
		begin
			step_errs = 0;
			name = $sformatf("step %0d %s", i + 1, kind_label(step_kind[i]));
			case (step_kind[i])
				"lock":  run_lock(name, step_arg[i][0], step_arg[i][1]);
				"loss":  run_loss(name, step_arg[i][0]);
				"rx":    run_reconfig(name, 1'b1, 1'b0, 2'(step_arg[i][0]), 2'd0,
					2'(step_arg[i][1]), 2'(step_arg[i][2]));
				"tx":    run_reconfig(name, 1'b0, 1'b1, 2'd0, 2'(step_arg[i][0]),
					2'(step_arg[i][1]), 2'(step_arg[i][2]));
				"both":  run_reconfig(name, 1'b1, 1'b1, 2'(step_arg[i][0]), 2'(step_arg[i][1]),
					2'(step_arg[i][2]), 2'(step_arg[i][3]));
				"frame": run_frame(name, step_arg[i][0], step_arg[i][1], step_arg[i][2]);
				default: report_problem(name, "unknown step kind in golden file");
			endcase
			if (step_errs == 0)
			begin
				pass_count++;
				$display("%s: pass", name);
			end
			else
			begin
				fail_count++;
				$display("%s: fail with %0d errors", name, step_errs);
			end
		end
		$display("Tests run %0d, passed %0d, failed %0d", step_count, pass_count, fail_count);
		if (fail_count == 0 && !load_failed && step_count > 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/dp_link_ctrl_golden.txt
# Columns: kind a b c d, unused columns are 0
# lock: low_at high_by | loss: recover_by | rx, tx: rate exp_rx exp_tx
# both: rx_rate tx_rate exp_rx exp_tx | frame: lines pixels exp_lines
# Rates: 0 RBR, 1 HBR, 2 HBR2, 3 reserved
lock 120 130 0 0
loss 140 0 0 0
rx 1 1 0 0
tx 2 1 2 0
rx 2 2 2 0
tx 0 2 0 0
both 1 2 1 2
both 0 1 0 1
rx 3 0 1 0
tx 3 0 1 0
both 3 2 0 2
rx 2 2 2 0
tx 1 2 1 0
frame 1 4 1 0
frame 3 5 3 0
frame 6 3 6 0
frame 10 2 10 0
frame 2 8 2 0
frame 4 1 4 0

// File: dp_link_ctrl.f
+incdir+rtl
rtl/dp_pkg.sv
rtl/wb_if.sv
rtl/lock_reset_seq.sv
rtl/reconfig_mgr.sv
rtl/xcvr_reconfig_regs.sv
rtl/video_sync_gen.sv
rtl/dp_link_ctrl.sv
tb/tb_dp_link_ctrl.sv
